// ==== project.f ====
verilog/spu_pkg.sv
verilog/spu_op_nop.sv
verilog/spu_op_srl.sv
verilog/spu_op_add.sv
verilog/spu_op_logic.sv
verilog/spu_lane.sv
tests/spu_lane_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the lane testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing --top-module spu_lane_tb -f project.f -o spu_lane_sim \
    && ./obj_dir/spu_lane_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation passed"
exit 0

// ==== tests/spu_lane_tb.sv ====
`default_nettype none

module spu_lane_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import spu_pkg::*;

    localparam int DRAIN_LIMIT = 20;   // edges allowed for the pipeline to empty

    // one result slot of the reference pipeline
    typedef struct packed {
        logic      valid;
        logic      clear;
        spu_data_t data;
        logic      carry;
    } slot_t;

    logic        clk;
    logic        rst_n;
    logic        cke;
    spu_instr_t  s_instr;
    spu_result_t m_result;

    slot_t       slot_q[$];            // accepted slots, oldest first
    spu_result_t exp_result;           // what m_result should show now
    int          in_flight = 0;        // valid slots not yet delivered
    int          max_in_flight = 0;    // most valid slots held in the stages at once

    int valid_errors  = 0;
    int data_errors   = 0;
    int carry_errors  = 0;
    int freeze_errors = 0;
    int other_errors  = 0;

    spu_lane spu_lane_i (
        .clk,
        .rst_n,
        .cke,
        .s_instr,
        .m_result
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // bitwise view of a logical shift, so amounts past the width fall off naturally
    function automatic spu_data_t zero_fill_shift(spu_data_t value, spu_shift_t amount);
        spu_data_t res;
        int        src;
        res = '0;
        for (int i = 0; i < SPU_DATA_BITS; i++) begin
            src = i + int'(amount);
            if (src < SPU_DATA_BITS) begin
                res[i] = value[src];
            end
        end
        return res;
    endfunction

    function automatic slot_t predict_slot(spu_instr_t instr);
        slot_t                  s;
        logic [SPU_DATA_BITS:0] wide;
        s.valid = instr.valid;
        s.clear = instr.clear;
        s.data  = '0;
        s.carry = 1'b0;
        case (instr.op)
            SPU_OP_SRL: begin
                s.data = zero_fill_shift(instr.data_a, instr.data_b[SPU_SHIFT_BITS-1:0]);
            end
            SPU_OP_ADD: begin
                wide    = {1'b0, instr.data_a} + {1'b0, instr.data_b};
                s.data  = wide[SPU_DATA_BITS-1:0];
                s.carry = wide[SPU_DATA_BITS];
            end
            SPU_OP_SUB: begin
                s.data  = instr.data_a - instr.data_b;
                s.carry = (instr.data_a >= instr.data_b);   // no borrow
            end
            SPU_OP_AND: s.data = instr.data_a & instr.data_b;
            SPU_OP_OR:  s.data = instr.data_a | instr.data_b;
            SPU_OP_XOR: s.data = instr.data_a ^ instr.data_b;
            default:    s.data = '0;
        endcase
        return s;
    endfunction

    function automatic int count_in_flight();
        int n;
        n = 0;
        foreach (slot_q[i]) begin
            if (slot_q[i].valid) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int total_errors();
        return valid_errors + data_errors + carry_errors + freeze_errors + other_errors;
    endfunction

    task automatic issue(input spu_op_t op, input spu_data_t a, input spu_data_t b,
                         input logic clear, input logic valid, input logic enable);
        spu_instr_t instr;
        instr.op     = op;
        instr.data_a = a;
        instr.data_b = b;
        instr.clear  = clear;
        instr.valid  = valid;
        @(posedge clk);
        s_instr <= instr;
        cke     <= enable;
    endtask

    task automatic directed_cases();
        issue(SPU_OP_SRL, 16'h8001, 16'h0000, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_SRL, 16'h8001, 16'h0001, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_SRL, 16'h8000, 16'h000f, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_SRL, 16'hffff, 16'h0010, 1'b0, 1'b1, 1'b1);   // shifted out
        issue(SPU_OP_SRL, 16'hffff, 16'h001f, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_SRL, 16'hf00f, 16'hffe3, 1'b0, 1'b1, 1'b1);   // only low bits count
        issue(SPU_OP_ADD, 16'hffff, 16'h0001, 1'b0, 1'b1, 1'b1);   // carry out
        issue(SPU_OP_ADD, 16'h1234, 16'h4321, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_SUB, 16'h0005, 16'h0003, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_SUB, 16'h0003, 16'h0005, 1'b0, 1'b1, 1'b1);   // borrow
        issue(SPU_OP_SUB, 16'h7777, 16'h7777, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_AND, 16'hf0f0, 16'h3c3c, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_OR,  16'hf0f0, 16'h3c3c, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_XOR, 16'hf0f0, 16'h3c3c, 1'b0, 1'b1, 1'b1);
        // idle slots, output must hold the XOR result
        repeat (3) issue(SPU_OP_ADD, 16'hdead, 16'hbeef, 1'b0, 1'b0, 1'b1);
        issue(SPU_OP_ADD, 16'hffff, 16'hffff, 1'b1, 1'b1, 1'b1);   // clear with valid
        issue(SPU_OP_XOR, 16'h1234, 16'h5678, 1'b0, 1'b1, 1'b1);
        issue(SPU_OP_OR,  16'h1111, 16'h2222, 1'b1, 1'b0, 1'b1);   // clear alone
        issue(SPU_OP_AND, 16'h00ff, 16'h0ff0, 1'b0, 1'b1, 1'b0);   // not accepted
        issue(SPU_OP_AND, 16'h00ff, 16'h0ff0, 1'b0, 1'b1, 1'b1);
        repeat (3) issue(SPU_OP_SRL, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0);
        repeat (SPU_LATENCY + 1) issue(SPU_OP_SRL, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic random_traffic(input int cycles);
        int low_left;
        low_left = 0;
        for (int n = 0; n < cycles; n++) begin
            if (low_left == 0 && $urandom_range(0, 7) == 0) begin
                low_left = $urandom_range(1, 4);   // stretch of frozen edges
            end
            issue(spu_op_t'(3'($urandom_range(0, 5))), 16'($urandom), 16'($urandom),
                  $urandom_range(0, 9) == 0, $urandom_range(0, 3) != 0, low_left == 0);
            if (low_left > 0) begin
                low_left--;
            end
        end
    endtask

    task automatic drain_pipeline(output bit timed_out);
        int waited;
        waited = 0;
        do begin
            issue(SPU_OP_SRL, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b1);
            @(negedge clk);   // model has taken this edge by now
            waited++;
        end while (in_flight != 0 && waited < DRAIN_LIMIT);
        timed_out = (in_flight != 0);
    endtask

    // reference pipeline, one slot per cke-high edge
    // the accepting edge is the first of the SPU_LATENCY edges
    always @(posedge clk) begin
        slot_t head;
        int    occupied;
        if (!rst_n) begin
            slot_q.delete();
            for (int i = 1; i < SPU_LATENCY; i++) begin
                slot_q.push_back('0);
            end
            exp_result = '0;
            in_flight  = 0;
        end else if (cke) begin
            slot_q.push_back(predict_slot(s_instr));
            occupied = count_in_flight();   // every stage, the output one included
            head = slot_q.pop_front();
            exp_result.valid = head.valid;
            if (head.clear) begin
                exp_result.data  = '0;
                exp_result.carry = 1'b0;
            end else if (head.valid) begin
                exp_result.data  = head.data;
                exp_result.carry = head.carry;
            end
            in_flight = count_in_flight();
            if (occupied > max_in_flight) begin
                max_in_flight = occupied;
            end
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            valid_check: assert (m_result.valid === exp_result.valid) else begin
                valid_errors++;
                $display("** Error: m_result.valid = %h, expected %h at %0t",
                         m_result.valid, exp_result.valid, $time);
            end
            data_check: assert (m_result.data === exp_result.data) else begin
                data_errors++;
                $display("** Error: m_result.data = %h, expected %h at %0t",
                         m_result.data, exp_result.data, $time);
            end
            carry_check: assert (m_result.carry === exp_result.carry) else begin
                carry_errors++;
                $display("** Error: m_result.carry = %h, expected %h at %0t",
                         m_result.carry, exp_result.carry, $time);
            end
        end
    end

    freeze_check: assert property (@(posedge clk) disable iff (!rst_n)
                                   !$past(cke) |-> $stable(m_result)) else begin
        freeze_errors++;
        $display("** Error: m_result = %h changed on an edge with cke low at %0t",
                 m_result, $time);
    end

    initial begin
        bit timed_out;
        rst_n   = 1'b0;
        cke     = 1'b0;
        s_instr = '0;
        void'($urandom(32'h59da));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_check: assert (m_result.valid === 1'b0 && m_result.data === '0) else begin
            other_errors++;
            $display("** Error: m_result.valid = %h, m_result.data = %h after reset",
                     m_result.valid, m_result.data);
        end
        directed_cases();
        random_traffic(500);
        drain_pipeline(timed_out);
        overlap_check: assert (max_in_flight >= 2) else begin
            other_errors++;
            $display("never more than one result in flight, pipelining not exercised");
        end
        $display("errors: valid %0d, data %0d, carry %0d, cke freeze %0d, other %0d",
                 valid_errors, data_errors, carry_errors, freeze_errors, other_errors);
        if (timed_out) begin
            $display("results still in flight after %0d drain edges", DRAIN_LIMIT);
            $display("Test failed");
        end else if (total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/spu_lane.sv ====
`default_nettype none

module spu_lane (
    input  var logic                 clk,
    input  var logic                 rst_n,      // async, active low
    input  var logic                 cke,        // low freezes the whole lane

    input  var spu_pkg::spu_instr_t  s_instr,
    output var spu_pkg::spu_result_t m_result
);

    import spu_pkg::*;

    logic       sub_sel;
    spu_shift_t shift_amt;

    spu_data_t  srl_data;
    spu_data_t  add_data;
    logic       add_carry;
    spu_data_t  logic_data;

    logic [$bits(spu_op_t)-1:0] dly_op_bits;
    spu_op_t                    dly_op;
    logic                       dly_valid;

    // decode for the operators
    assign sub_sel   = (s_instr.op == SPU_OP_SUB);
    assign shift_amt = s_instr.data_b[SPU_SHIFT_BITS-1:0];   // low bits of b

    spu_op_srl #(
        .LATENCY (SPU_LATENCY)
    ) u_srl (
        .clk,
        .rst_n,
        .cke,
        .s_shift (shift_amt),
        .s_data  (s_instr.data_a),
        .s_clear (s_instr.clear),
        .s_valid (s_instr.valid),
        .m_data  (srl_data)
    );

    spu_op_add #(
        .LATENCY (SPU_LATENCY)
    ) u_add (
        .clk,
        .rst_n,
        .cke,
        .s_data_a (s_instr.data_a),
        .s_data_b (s_instr.data_b),
        .s_sub    (sub_sel),
        .s_clear  (s_instr.clear),
        .s_valid  (s_instr.valid),
        .m_data   (add_data),
        .m_carry  (add_carry)
    );

    spu_op_logic #(
        .LATENCY (SPU_LATENCY)
    ) u_logic (
        .clk,
        .rst_n,
        .cke,
        .s_op     (s_instr.op),
        .s_data_a (s_instr.data_a),
        .s_data_b (s_instr.data_b),
        .s_clear  (s_instr.clear),
        .s_valid  (s_instr.valid),
        .m_data   (logic_data)
    );

    // opcode travels alongside the operators, a clear leaves it at SRL
    spu_op_nop #(
        .LATENCY   (SPU_LATENCY),
        .DATA_BITS ($bits(spu_op_t))
    ) u_op_delay (
        .clk,
        .rst_n,
        .cke,
        .s_data  (s_instr.op),
        .s_clear (s_instr.clear),
        .s_valid (s_instr.valid),
        .m_data  (dly_op_bits),
        .m_valid (dly_valid)
    );

    assign dly_op = spu_op_t'(dly_op_bits);

    // result select by the opcode that went in with this slot
    always_comb begin
        m_result.valid = dly_valid;
        m_result.carry = 1'b0;                       // only add/sub drive a carry
        case (dly_op)
            SPU_OP_SRL: begin
                m_result.data = srl_data;
            end
            SPU_OP_ADD, SPU_OP_SUB: begin
                m_result.data  = add_data;
                m_result.carry = add_carry;
            end
            SPU_OP_AND, SPU_OP_OR, SPU_OP_XOR: begin
                m_result.data = logic_data;
            end
            default: begin
                m_result.data = SPU_CLEAR_DATA;      // undefined opcode
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/spu_op_add.sv ====
`default_nettype none

module spu_op_add #(
    parameter int LATENCY = 1   // enabled edges through the delay line
) (
    input  var logic               clk,
    input  var logic               rst_n,
    input  var logic               cke,

    input  var spu_pkg::spu_data_t s_data_a,
    input  var spu_pkg::spu_data_t s_data_b,
    input  var logic               s_sub,      // a - b instead of a + b
    input  var logic               s_clear,
    input  var logic               s_valid,

    output var spu_pkg::spu_data_t m_data,
    output var logic               m_carry     // 1 on subtract means no borrow
);

    import spu_pkg::*;

    // carry sits on top so the pair shares one delay line
    typedef struct packed {
        logic      carry;
        spu_data_t data;
    } sum_t;

    spu_data_t st0_b;
    sum_t      st0_sum;
    sum_t      st1_sum;

    assign st0_b = s_sub ? ~s_data_b : s_data_b;   // two's complement with the +1 below

    assign st0_sum = {1'b0, s_data_a} + {1'b0, st0_b} + {{SPU_DATA_BITS{1'b0}}, s_sub};

    spu_op_nop #(
        .LATENCY   (LATENCY),
        .DATA_BITS ($bits(sum_t))
    ) u_delay (
        .clk,
        .rst_n,
        .cke,
        .s_data  (st0_sum),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (st1_sum),
        .m_valid ()
    );

    assign m_data  = st1_sum.data;
    assign m_carry = st1_sum.carry;

endmodule

`default_nettype wire

// ==== verilog/spu_op_logic.sv ====
`default_nettype none

module spu_op_logic #(
    parameter int LATENCY = 1   // enabled edges through the delay line
) (
    input  var logic               clk,
    input  var logic               rst_n,
    input  var logic               cke,

    input  var spu_pkg::spu_op_t   s_op,       // picks and / or / xor
    input  var spu_pkg::spu_data_t s_data_a,
    input  var spu_pkg::spu_data_t s_data_b,
    input  var logic               s_clear,
    input  var logic               s_valid,

    output var spu_pkg::spu_data_t m_data
);

    import spu_pkg::*;

    spu_data_t st0_data;

    always_comb begin
        case (s_op)
            SPU_OP_AND: st0_data = s_data_a & s_data_b;
            SPU_OP_OR:  st0_data = s_data_a | s_data_b;
            SPU_OP_XOR: st0_data = s_data_a ^ s_data_b;
            default:    st0_data = '0;                  // not a logic op
        endcase
    end

    spu_op_nop #(
        .LATENCY   (LATENCY),
        .DATA_BITS ($bits(spu_data_t))
    ) u_delay (
        .clk,
        .rst_n,
        .cke,
        .s_data  (st0_data),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_data),
        .m_valid ()
    );

endmodule

`default_nettype wire

// ==== verilog/spu_op_nop.sv ====
`default_nettype none

module spu_op_nop #(
    parameter int LATENCY   = 1,   // number of register stages
    parameter int DATA_BITS = 8    // payload width
) (
    input  var logic                 clk,
    input  var logic                 rst_n,     // async, active low
    input  var logic                 cke,       // stages advance only when high

    input  var logic [DATA_BITS-1:0] s_data,
    input  var logic                 s_clear,   // forces the payload to the clear value
    input  var logic                 s_valid,   // loads the payload

    output var logic [DATA_BITS-1:0] m_data,
    output var logic                 m_valid
);

    import spu_pkg::*;

    localparam logic [DATA_BITS-1:0] CLEAR_DATA = DATA_BITS'(SPU_CLEAR_DATA);

    // index 0 is the input side, index LATENCY the output side
    logic [DATA_BITS-1:0] pipe_data  [LATENCY+1];
    logic                 pipe_clear [LATENCY+1];
    logic                 pipe_valid [LATENCY+1];

    assign pipe_data[0]  = s_data;
    assign pipe_clear[0] = s_clear;
    assign pipe_valid[0] = s_valid;

    for (genvar i = 1; i <= LATENCY; i++) begin : g_stage
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                pipe_data[i]  <= CLEAR_DATA;
                pipe_clear[i] <= 1'b0;
                pipe_valid[i] <= 1'b0;
            end else if (cke) begin
                pipe_clear[i] <= pipe_clear[i-1];   // clear rides along with valid
                pipe_valid[i] <= pipe_valid[i-1];
                if (pipe_clear[i-1]) begin
                    pipe_data[i] <= CLEAR_DATA;        // clear beats valid
                end else if (pipe_valid[i-1]) begin
                    pipe_data[i] <= pipe_data[i-1];
                end
            end
        end
    end

    // Without stages the clear has to be applied on the way through,
    // otherwise the last stage has already taken care of it.
    if (LATENCY == 0) begin : g_comb
        assign m_data = pipe_clear[0] ? CLEAR_DATA : pipe_data[0];
    end else begin : g_reg
        assign m_data = pipe_data[LATENCY];
    end

    assign m_valid = pipe_valid[LATENCY];

endmodule

`default_nettype wire

// ==== verilog/spu_op_srl.sv ====
`default_nettype none

module spu_op_srl #(
    parameter int LATENCY = 1   // enabled edges through the delay line
) (
    input  var logic                clk,
    input  var logic                rst_n,
    input  var logic                cke,

    input  var spu_pkg::spu_shift_t s_shift,   // shift amount
    input  var spu_pkg::spu_data_t  s_data,    // value to shift
    input  var logic                s_clear,
    input  var logic                s_valid,

    output var spu_pkg::spu_data_t  m_data
);

    import spu_pkg::*;

    spu_data_t st0_data;

    // zero fill, amounts of 16 and up leave nothing
    assign st0_data = s_data >> s_shift;

    spu_op_nop #(
        .LATENCY   (LATENCY),
        .DATA_BITS ($bits(spu_data_t))
    ) u_delay (
        .clk,
        .rst_n,
        .cke,
        .s_data  (st0_data),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_data),
        .m_valid ()              // lane takes valid from the opcode line
    );

endmodule

`default_nettype wire

// ==== verilog/spu_pkg.sv ====
`default_nettype none

package spu_pkg;

    // lane geometry
    localparam int SPU_DATA_BITS  = 16;   // operand and result width
    localparam int SPU_SHIFT_BITS = 5;    // amounts 16..31 shift everything out
    localparam int SPU_LATENCY    = 2;    // enabled edges from s_instr to m_result

    typedef logic [SPU_DATA_BITS-1:0]  spu_data_t;
    typedef logic [SPU_SHIFT_BITS-1:0] spu_shift_t;

    localparam spu_data_t SPU_CLEAR_DATA = '0;   // value of a cleared stage

    // zero encodes SRL, which is what a cleared opcode stage selects
    typedef enum logic [2:0] {
        SPU_OP_SRL = 3'd0,
        SPU_OP_ADD = 3'd1,
        SPU_OP_SUB = 3'd2,
        SPU_OP_AND = 3'd3,
        SPU_OP_OR  = 3'd4,
        SPU_OP_XOR = 3'd5
    } spu_op_t;

    // one instruction per cycle into the lane
    typedef struct packed {
        spu_op_t   op;
        spu_data_t data_a;
        spu_data_t data_b;   // low bits double as shift amount
        logic      clear;
        logic      valid;
    } spu_instr_t;

    // lane output, SPU_LATENCY enabled edges after the instruction
    typedef struct packed {
        spu_data_t data;
        logic      carry;    // add/sub only
        logic      valid;
    } spu_result_t;

endpackage

`default_nettype wire
